// File: logic/fifo_pkg.sv
//========================================
// FIFO pointer, delay and line FSM types
// pointers carry one wrap bit above the address
//========================================
`default_nettype none

`include "sensor_cfg.svh"

package fifo_pkg;

    typedef logic [`SENS_FIFO_AW:0] fifo_ptr_t; // addr + wrap bit

    typedef logic [3:0] dly_t;                  // delay select, 0..15

    // line reformer FSM
    typedef enum logic [1:0] {
        IDLE,       // waiting for any word
        PRIME,      // single read of the head word
        WAIT_START, // line seen, let the FIFO fill
        STREAM      // read every cycle until line end
    } line_state_t;

endpackage

`default_nettype wire

// File: logic/fifo_rd_if.sv
//========================================
// read side of the cross-clock FIFO, iclk domain
// fields always show the head word
// re advances the head on the next iclk edge
//========================================
`default_nettype none

interface fifo_rd_if;

    logic            nempty;   // head word is valid
    pixel_pkg::pix_t pxd;      // head pixel
    logic            line_act; // head line-active bit
    logic            sof_f;    // head frame start flag
    logic            eof_f;    // head frame end flag
    logic            re;       // read strobe

    modport producer (output nempty, pxd, line_act, sof_f, eof_f, input re);

    modport consumer (input nempty, pxd, line_act, sof_f, eof_f, output re);

endinterface

`default_nettype wire

// File: logic/gray_fifo_cdc.sv
//========================================
// dual-clock FIFO, sclk write and iclk read
// Gray pointers, two-flop sync each way
// a write into a full FIFO is dropped
// a read while empty leaves the head in place
//========================================
`default_nettype none

`include "sensor_cfg.svh"

module gray_fifo_cdc (
    input  wire                        sclk,
    input  wire                        srst,
    input  wire                        iclk,
    input  wire                        prst,
    input  wire                        we,
    input  wire pixel_pkg::sens_word_t wdata,
    fifo_rd_if.producer                rd
);

    localparam int AW    = `SENS_FIFO_AW;
    localparam int DEPTH = 1 << AW;

    pixel_pkg::sens_word_t mem [DEPTH]; // async read, sclk write

    // write domain
    fifo_pkg::fifo_ptr_t wbin;      // binary write pointer
    fifo_pkg::fifo_ptr_t wbin_nxt;
    fifo_pkg::fifo_ptr_t wgray;     // published to iclk
    fifo_pkg::fifo_ptr_t rq1;       // read gray, first sync flop
    fifo_pkg::fifo_ptr_t rq2;       // read gray in sclk domain
    logic                full;
    logic                wr_en;

    // read domain
    fifo_pkg::fifo_ptr_t rbin;      // binary read pointer
    fifo_pkg::fifo_ptr_t rbin_nxt;
    fifo_pkg::fifo_ptr_t rgray;     // published to sclk
    fifo_pkg::fifo_ptr_t wq1;       // write gray, first sync flop
    fifo_pkg::fifo_ptr_t wq2;       // write gray in iclk domain
    logic                nempty;
    logic                rd_en;
    pixel_pkg::sens_word_t head;

    function automatic fifo_pkg::fifo_ptr_t bin2gray(input fifo_pkg::fifo_ptr_t b);
        return b ^ (b >> 1);
    endfunction

    // sclk side
    assign wbin_nxt = wbin + 1'b1;

    // full when the gray pointers differ only in the two top bits
    assign full  = (wgray == {~rq2[AW:AW-1], rq2[AW-2:0]});
    assign wr_en = we & ~full;

    always_ff @(posedge sclk) begin
        if (srst) begin
            wbin  <= '0;
            wgray <= '0;
            rq1   <= '0;
            rq2   <= '0;
        end else begin
            rq1 <= rgray;
            rq2 <= rq1;
            if (wr_en) begin
                wbin  <= wbin_nxt;
                wgray <= bin2gray(wbin_nxt);
            end
        end
    end

    always_ff @(posedge sclk) begin
        if (wr_en) begin
            mem[wbin[AW-1:0]] <= wdata;
        end
    end

    // iclk side
    assign rbin_nxt = rbin + 1'b1;
    assign nempty   = (wq2 != rgray);   // synced write ptr ahead of read ptr
    assign rd_en    = rd.re & nempty;   // guard against underrun

    always_ff @(posedge iclk) begin
        if (prst) begin
            rbin  <= '0;
            rgray <= '0;
            wq1   <= '0;
            wq2   <= '0;
        end else begin
            wq1 <= wgray;
            wq2 <= wq1;
            if (rd_en) begin
                rbin  <= rbin_nxt;
                rgray <= bin2gray(rbin_nxt);
            end
        end
    end

    // head word is stable once its write pointer has passed the sync
    assign head = mem[rbin[AW-1:0]];

    assign rd.nempty = nempty;
    assign {rd.eof_f, rd.sof_f, rd.line_act, rd.pxd} = head; // unpack msb first

endmodule

`default_nettype wire

// File: logic/line_reformer.sv
//========================================
// iclk-domain line rebuild from FIFO words
// one priming read finds the line start, then
// waits SENS_START_DLY cycles and streams the line
// the streamed read does not check nempty
//========================================
`default_nettype none

`include "sensor_cfg.svh"

module line_reformer (
    input  wire          iclk,
    input  wire          prst,
    fifo_rd_if.consumer  rd,
    output pixel_pkg::pix_t pxd_out,
    output logic         data_valid,
    output logic         sof,
    output logic         eof
);

    fifo_pkg::line_state_t state;
    fifo_pkg::line_state_t state_nxt;
    logic start_pls; // first line word seen by the priming read
    logic start_dly; // same pulse, SENS_START_DLY later

    // priming read only with data present; streaming reads blind
    assign rd.re = ((state == fifo_pkg::PRIME) & rd.nempty) | (state == fifo_pkg::STREAM);

    // prime only follows an inactive word, so a set bit marks a line start
    assign start_pls = (state == fifo_pkg::PRIME) & rd.re & rd.line_act;

    always_comb begin
        state_nxt = state;
        case (state)
            fifo_pkg::IDLE: begin
                if (rd.nempty) state_nxt = fifo_pkg::PRIME;
            end
            fifo_pkg::PRIME: begin
                state_nxt = start_pls ? fifo_pkg::WAIT_START : fifo_pkg::IDLE; // flag word
            end
            fifo_pkg::WAIT_START: begin
                if (start_dly) state_nxt = fifo_pkg::STREAM; // FIFO half full by now
            end
            fifo_pkg::STREAM: begin
                if (!rd.line_act) state_nxt = fifo_pkg::IDLE; // tail word read
            end
            default: state_nxt = fifo_pkg::IDLE;
        endcase
    end

    pulse_delay u_start_dly (
        .iclk (iclk),
        .prst (prst),
        .dly  (fifo_pkg::dly_t'(`SENS_START_DLY)),
        .din  (start_pls),
        .dout (start_dly)
    );

    always_ff @(posedge iclk) begin
        if (prst) begin
            state      <= fifo_pkg::IDLE;
            data_valid <= 1'b0;
            sof        <= 1'b0;
            eof        <= 1'b0;
        end else begin
            state      <= state_nxt;
            data_valid <= (state_nxt == fifo_pkg::STREAM);
            sof        <= rd.re & rd.sof_f; // one cycle after the flagged read
            eof        <= rd.re & rd.eof_f;
        end
    end

    // holds the primed first pixel until streaming starts
    always_ff @(posedge iclk) begin
        if (rd.re) begin
            pxd_out <= rd.pxd;
        end
    end

endmodule

`default_nettype wire

// File: logic/pixel_pkg.sv
//========================================
// pixel and FIFO word types
// word layout from msb: eof, sof, line active, pixel
//========================================
`default_nettype none

`include "sensor_cfg.svh"

package pixel_pkg;

    // one sensor pixel
    typedef logic [`SENS_PIX_W-1:0] pix_t;

    // one FIFO word with three flag bits above the pixel
    typedef logic [`SENS_PIX_W+2:0] sens_word_t;

endpackage

`default_nettype wire

// File: logic/pulse_delay.sv
//========================================
// programmable delay of a one-bit pulse
// dout follows din by exactly dly iclk cycles
// dly of 0 passes din straight through
//========================================
`default_nettype none

module pulse_delay (
    input  wire                  iclk,
    input  wire                  prst,
    input  wire fifo_pkg::dly_t  dly,
    input  wire                  din,
    output logic                 dout
);

    logic [14:0] sr;   // sr[k] is din delayed k+1
    logic [15:0] taps; // 16 taps, delays 0..15

    always_ff @(posedge iclk) begin
        if (prst) begin
            sr <= '0;
        end else begin
            sr <= {sr[13:0], din};
        end
    end

    assign taps = {sr, din};
    assign dout = taps[dly]; // tap select

endmodule

`default_nettype wire

// File: logic/sensor_cfg.svh
//========================================
// build-time sizes for the sensor FIFO path
// SENS_FIFO_AW must be 2 or more for the full flag compare
// SENS_START_DLY has to fit the 4-bit delay select
//========================================
`ifndef SENSOR_CFG_SVH
`define SENSOR_CFG_SVH

// pixel width in bits
`define SENS_PIX_W 12

// FIFO address bits (4 gives 16 entries)
`define SENS_FIFO_AW 4

// iclk cycles from the line-start pulse to streaming
// set near half the FIFO depth
`define SENS_START_DLY 7

`endif

// File: logic/sensor_fifo.sv
//========================================
// sensor stream into the iclk domain
// sclk/srst sensor side, iclk/prst output side
// iclk must keep up on average as there is no back-pressure
// data_valid is continuous for each line
//========================================
`default_nettype none

module sensor_fifo (
    input  wire             sclk,
    input  wire             srst,
    input  wire             iclk,
    input  wire             prst,
    input  wire pixel_pkg::pix_t pxd_in,
    input  wire             vact,
    input  wire             hact,
    output pixel_pkg::pix_t pxd_out,
    output logic            data_valid,
    output logic            sof,
    output logic            eof
);

    logic                  we;    // sclk domain write strobe
    pixel_pkg::sens_word_t wdata; // packed flags and pixel

    fifo_rd_if rd_if ();

    sensor_frame_marker u_marker (
        .sclk   (sclk),
        .srst   (srst),
        .pxd_in (pxd_in),
        .vact   (vact),
        .hact   (hact),
        .we     (we),
        .wdata  (wdata)
    );

    gray_fifo_cdc u_fifo (
        .sclk  (sclk),
        .srst  (srst),
        .iclk  (iclk),
        .prst  (prst),
        .we    (we),
        .wdata (wdata),
        .rd    (rd_if.producer)
    );

    line_reformer u_reformer (
        .iclk       (iclk),
        .prst       (prst),
        .rd         (rd_if.consumer),
        .pxd_out    (pxd_out),
        .data_valid (data_valid),
        .sof        (sof),
        .eof        (eof)
    );

endmodule

`default_nettype wire

// File: logic/sensor_frame_marker.sv
//========================================
// sensor-domain word builder, clocked by sclk
// one cycle of registering from strobes to we
// writes during the line plus one trailing word
//========================================
`default_nettype none

module sensor_frame_marker (
    input  wire                   sclk,
    input  wire                   srst,
    input  wire pixel_pkg::pix_t  pxd_in,
    input  wire                   vact,
    input  wire                   hact,
    output logic                  we,
    output pixel_pkg::sens_word_t wdata
);

    logic vact_r; // previous frame strobe
    logic hact_r; // previous line strobe
    logic sof_e;  // frame start edge
    logic eof_e;  // frame end edge

    assign sof_e = vact & ~vact_r;  // rising vact
    assign eof_e = vact_r & ~vact;  // falling vact

    always_ff @(posedge sclk) begin
        if (srst) begin
            vact_r <= 1'b0;
            hact_r <= 1'b0;
            we     <= 1'b0;
        end else begin
            vact_r <= vact;
            hact_r <= hact;
            we     <= hact | hact_r | sof_e | eof_e; // line, its tail, or a frame edge
        end
    end

    // flags and pixel of the word written with we
    always_ff @(posedge sclk) begin
        wdata <= {eof_e, sof_e, hact, pxd_in};
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the sensor FIFO testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_sensor_fifo -f src.f \
    || { echo "verilator build failed"; exit 1; }
sim_out="$(./obj_dir/Vtb_sensor_fifo)"
echo "$sim_out"
echo "$sim_out" | grep -qx "TB PASSED" && exit 0 || exit 1

// File: src.f
+incdir+logic
logic/pixel_pkg.sv
logic/fifo_pkg.sv
logic/fifo_rd_if.sv
logic/sensor_frame_marker.sv
logic/gray_fifo_cdc.sv
logic/pulse_delay.sv
logic/line_reformer.sv
logic/sensor_fifo.sv
test/tb_sensor_fifo.sv

// File: test/tb_sensor_fifo.sv
//========================================
// sclk period 9 against iclk period 8
// line gaps of about 10 sclk or more keep the
// FIFO from backing up as the DUT has no back-pressure
// lines start and end inside vact high and never on a vact edge
//========================================
`default_nettype none

module tb_sensor_fifo;

    localparam int          N_ROWS   = 6;
    localparam logic [31:0] RNG_SEED = 32'h3e69;

    // frame table with one row per frame
    localparam int unsigned ROW_LINES [N_ROWS] = '{3, 4, 2, 5, 1, 3};
    localparam int unsigned ROW_LEN   [N_ROWS] = '{8, 1, 24, 16, 1, 20};   // pixels per line
    localparam int unsigned ROW_GAP   [N_ROWS] = '{12, 10, 10, 11, 10, 14}; // hact low cycles
    localparam int unsigned ROW_IDLE  [N_ROWS] = '{20, 1, 1, 30, 1, 8};    // vact low after frame
    localparam logic [31:0] ROW_SEED  [N_ROWS] = '{32'h0000_a5a5, 32'h0000_1234,
                                                   32'h0000_7e21, 32'h0019_c0de,
                                                   32'h0000_0042, 32'h0003_3c3c};

    logic            sclk;
    logic            srst;
    logic            iclk;
    logic            prst;
    pixel_pkg::pix_t pxd_in;
    logic            vact;
    logic            hact;
    pixel_pkg::pix_t pxd_out;
    logic            data_valid;
    logic            sof;
    logic            eof;

    pixel_pkg::pix_t exp_q [$]; // pixels in sensor order
    int              errors;
    int              checks;
    int              mon_frame;  // frames closed by eof
    int              run_len;    // length of the current valid run
    int              runs_seen;  // runs in the open frame
    int              frame_err0; // error count when the frame opened
    logic            in_frame;
    logic            mon_on;

    sensor_fifo i_dut (
        .sclk       (sclk),
        .srst       (srst),
        .iclk       (iclk),
        .prst       (prst),
        .pxd_in     (pxd_in),
        .vact       (vact),
        .hact       (hact),
        .pxd_out    (pxd_out),
        .data_valid (data_valid),
        .sof        (sof),
        .eof        (eof)
    );

    always #4 iclk = ~iclk; // period 8

    always begin            // period 9 with uneven halves
        #5 sclk = 1'b1;
        #4 sclk = 1'b0;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // sensor time of all frames plus slack for reset and reader latency
    function automatic int unsigned time_limit();
        int unsigned t;
        t = 2000;
        for (int r = 0; r < N_ROWS; r++) begin
            t += ROW_LINES[r] * (ROW_LEN[r] + ROW_GAP[r]) * 9;
            t += (ROW_GAP[r] + ROW_IDLE[r]) * 9 + 300; // lead-in, idle, margin
        end
        return t;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // drives one sclk cycle of sensor inputs 1 unit after the edge
    task automatic drive_cycle(input logic v, input logic h, input pixel_pkg::pix_t p);
        @(posedge sclk);
        #1;
        vact   = v;
        hact   = h;
        pxd_in = p;
    endtask

    task automatic send_frame(input int r);
        logic [31:0]     rng;
        pixel_pkg::pix_t pix;
        rng = xorshift32(RNG_SEED ^ ROW_SEED[r]);
        for (int c = 0; c < ROW_GAP[r]; c++) drive_cycle(1'b1, 1'b0, '0); // vact lead-in
        for (int ln = 0; ln < ROW_LINES[r]; ln++) begin
            for (int px = 0; px < ROW_LEN[r]; px++) begin
                rng = xorshift32(rng);
                pix = pixel_pkg::pix_t'(rng);
                exp_q.push_back(pix);
                drive_cycle(1'b1, 1'b1, pix);
            end
            for (int c = 0; c < ROW_GAP[r]; c++) drive_cycle(1'b1, 1'b0, '0); // line gap
        end
        for (int c = 0; c < ROW_IDLE[r]; c++) drive_cycle(1'b0, 1'b0, '0); // between frames
    endtask

    // outputs change on rising iclk and are sampled on the falling edge
    always @(negedge iclk) begin : output_monitor
        int row;
        row = (mon_frame < N_ROWS) ? mon_frame : N_ROWS - 1;
        if (mon_on) begin
            if ($isunknown({data_valid, sof, eof})) begin
                $display("Error: unknown value on data_valid, sof or eof");
                errors++;
            end
            if (!in_frame) begin // no pixel outside a frame
                check_value("data_valid", 32'(data_valid), 32'd0);
            end
            if (data_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Error: valid pixel with no expected pixel left");
                    errors++;
                end else begin
                    check_value("pxd_out", 32'(pxd_out), 32'(exp_q.pop_front()));
                end
                run_len++;
            end else if (run_len != 0) begin // run just ended
                check_value("line_length", run_len, ROW_LEN[row]);
                runs_seen++;
                run_len = 0;
            end
            if (sof) begin
                if (in_frame) begin
                    $display("Error: frame start pulse inside an open frame");
                    errors++;
                end
                in_frame   = 1'b1;
                runs_seen  = 0;
                frame_err0 = errors;
            end
            if (eof) begin
                if (!in_frame) begin
                    $display("Error: frame end pulse with no open frame");
                    errors++;
                end else begin
                    check_value("line_count", runs_seen, ROW_LINES[row]);
                    $display("frame %0d: %0d lines of %0d pixels, %0d errors",
                             mon_frame, runs_seen, ROW_LEN[row], errors - frame_err0);
                    in_frame = 1'b0;
                    mon_frame++;
                end
            end
        end
    end

    initial begin
        #(time_limit());
        $display("Error: timeout, the DUT did not close all frames in time");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int r;
        iclk       = 1'b0;
        sclk       = 1'b0;
        prst       = 1'b1;
        srst       = 1'b1;
        pxd_in     = '0;
        vact       = 1'b0;
        hact       = 1'b0;
        errors     = 0;
        checks     = 0;
        mon_frame  = 0;
        run_len    = 0;
        runs_seen  = 0;
        frame_err0 = 0;
        in_frame   = 1'b0;
        mon_on     = 1'b0;
        fork
            begin
                repeat (5) @(posedge iclk);
                #1 prst = 1'b0;
            end
            begin
                repeat (5) @(posedge sclk);
                #1 srst = 1'b0;
            end
        join
        mon_on = 1'b1;
        for (r = 0; r < N_ROWS; r++) begin
            send_frame(r);
        end
        wait (mon_frame == N_ROWS);
        repeat (20) @(posedge iclk); // catch any late output
        check_value("pixels_left", exp_q.size(), 32'd0);
        $display("%0d frames, %0d checks, %0d errors", mon_frame, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
